/* design/cache_pkg.sv */
package cache_pkg;

  // ------------------------------------------------------------
  // address and data layout
  // ------------------------------------------------------------
  localparam int saddr_width = 16;
  localparam int blk_width   = 32;
  localparam int num_way     = 4;
  localparam int num_set     = 16;
  localparam int way_width   = 2;
  // set index sits in the low address bits
  localparam int idx_width   = 4;
  localparam int tag_width   = saddr_width - idx_width;

  // ------------------------------------------------------------
  // line coherence state
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    invalid   = 3'd0,
    shared    = 3'd1,
    exclusive = 3'd2,
    modified  = 3'd3,
    migrated  = 3'd4
  } blk_state_t;

  // core request ops
  typedef enum logic [1:0] {
    cdreq_rd  = 2'd0,
    cdreq_md  = 2'd1,
    cdreq_wb  = 2'd2,
    cdreq_rfo = 2'd3
  } cdreq_op_t;

  // downstream request ops
  typedef enum logic [1:0] {
    sdreq_rd  = 2'd0,
    sdreq_rfo = 2'd1,
    sdreq_inv = 2'd2
  } sdreq_op_t;

  // downstream response kind, snoop means another cache supplied the line
  typedef enum logic {
    sursp_snoop = 1'b0,
    sursp_fetch = 1'b1
  } sursp_rsp_t;

  // request FSM
  typedef enum logic [2:0] {
    st_idle       = 3'd0,
    st_allocate   = 3'd1,
    st_init_sdreq = 3'd2,
    st_wait_sursp = 3'd3,
    st_send_rsp   = 3'd4
  } req_state_t;

endpackage

/* design/req_slot.sv */
`timescale 1ns/1ps

module req_slot (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                cdreq_valid,
  input  cache_pkg::cdreq_op_t                cdreq_op,
  input  logic [cache_pkg::saddr_width-1:0]   cdreq_addr,
  input  logic [cache_pkg::blk_width-1:0]     cdreq_data,
  input  logic                                slot_release,
  output logic                                cdreq_ready,
  output logic                                full,
  output cache_pkg::cdreq_op_t                op_bf,
  output logic [cache_pkg::saddr_width-1:0]   addr_bf,
  output logic [cache_pkg::blk_width-1:0]     data_bf
);

  logic accept;

  // slot open whenever nothing is held
  assign cdreq_ready = !full;
  assign accept      = cdreq_valid && cdreq_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end else if (slot_release) begin
      full <= 1'b0;
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (accept) begin
      op_bf   <= cdreq_op;
      addr_bf <= cdreq_addr;
      data_bf <= cdreq_data;
    end
  end

  // controller only lets go of a request that is actually held
  a_release_when_full : assert property (
    @(posedge clk) disable iff (!rst_n)
    slot_release |-> full
  );

endmodule

/* design/line_store.sv */
`timescale 1ns/1ps

module line_store (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [cache_pkg::saddr_width-1:0]   addr_bf,
  input  logic [cache_pkg::way_width-1:0]     victim_way,
  input  logic                                st_we,
  input  cache_pkg::blk_state_t               st_nxt,
  input  logic                                tag_we,
  input  logic                                dat_we,
  input  logic [cache_pkg::blk_width-1:0]     dat_in,
  output logic                                hit,
  output logic [cache_pkg::way_width-1:0]     sel_way,
  output cache_pkg::blk_state_t               sel_state,
  output logic [cache_pkg::blk_width-1:0]     sel_data
);

  // ------------------------------------------------------------
  // line arrays
  // ------------------------------------------------------------
  cache_pkg::blk_state_t                st_mem  [cache_pkg::num_set][cache_pkg::num_way];
  logic [cache_pkg::tag_width-1:0]      tag_mem [cache_pkg::num_set][cache_pkg::num_way];
  logic [cache_pkg::blk_width-1:0]      dat_mem [cache_pkg::num_set][cache_pkg::num_way];

  logic [cache_pkg::idx_width-1:0]      idx;
  logic [cache_pkg::tag_width-1:0]      tag;
  logic [cache_pkg::num_way-1:0]        way_hit;
  logic [cache_pkg::way_width-1:0]      hit_way;

  assign idx = addr_bf[cache_pkg::idx_width-1:0];
  assign tag = addr_bf[cache_pkg::saddr_width-1:cache_pkg::idx_width];

  // ------------------------------------------------------------
  // four-way lookup
  // ------------------------------------------------------------
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < cache_pkg::num_way; w++) begin
      way_hit[w] = (st_mem[idx][w] != cache_pkg::invalid) && (tag_mem[idx][w] == tag);
      if (way_hit[w] && !hit) begin
        hit     = 1'b1;
        hit_way = cache_pkg::way_width'(w);
      end
    end
  end

  // miss lands in the LRU victim
  assign sel_way   = hit ? hit_way : victim_way;
  assign sel_state = st_mem[idx][sel_way];
  assign sel_data  = dat_mem[idx][sel_way];

  // ------------------------------------------------------------
  // line writes
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < cache_pkg::num_set; s++) begin
        for (int w = 0; w < cache_pkg::num_way; w++) begin
          st_mem[s][w] <= cache_pkg::invalid;
        end
      end
    end else if (st_we) begin
      st_mem[idx][sel_way] <= st_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_we) begin
      tag_mem[idx][sel_way] <= tag;
    end
    if (dat_we) begin
      dat_mem[idx][sel_way] <= dat_in;
    end
  end

endmodule

/* design/lru_tracker.sv */
`timescale 1ns/1ps

module lru_tracker (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [cache_pkg::idx_width-1:0]     set_idx,
  input  logic                                touch,
  input  logic [cache_pkg::way_width-1:0]     touch_way,
  output logic [cache_pkg::way_width-1:0]     victim_way
);

  // age 0 is oldest, num_way-1 is most recent
  logic [cache_pkg::way_width-1:0] ages [cache_pkg::num_set][cache_pkg::num_way];
  logic [cache_pkg::way_width-1:0] touch_age;
  logic                            found;

  assign touch_age = ages[set_idx][touch_way];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < cache_pkg::num_set; s++) begin
        for (int w = 0; w < cache_pkg::num_way; w++) begin
          ages[s][w] <= cache_pkg::way_width'(w);
        end
      end
    end else if (touch) begin
      for (int w = 0; w < cache_pkg::num_way; w++) begin
        if (ages[set_idx][w] > touch_age) begin
          ages[set_idx][w] <= ages[set_idx][w] - 1'b1;
        end else if (cache_pkg::way_width'(w) == touch_way) begin
          ages[set_idx][w] <= cache_pkg::way_width'(cache_pkg::num_way - 1);
        end
      end
    end
  end

  // lowest numbered way holding age 0
  always_comb begin
    victim_way = '0;
    found      = 1'b0;
    for (int w = 0; w < cache_pkg::num_way; w++) begin
      if (!found && ages[set_idx][w] == '0) begin
        victim_way = cache_pkg::way_width'(w);
        found      = 1'b1;
      end
    end
  end

endmodule

/* design/core_req_ctrl.sv */
`timescale 1ns/1ps

module core_req_ctrl (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                full,
  input  cache_pkg::cdreq_op_t                op_bf,
  input  logic [cache_pkg::saddr_width-1:0]   addr_bf,
  input  logic [cache_pkg::blk_width-1:0]     data_bf,
  input  logic                                hit,
  input  cache_pkg::blk_state_t               sel_state,
  input  logic [cache_pkg::blk_width-1:0]     sel_data,
  input  logic                                sdreq_ready,
  input  logic                                sursp_valid,
  input  cache_pkg::sursp_rsp_t               sursp_rsp,
  input  logic [cache_pkg::blk_width-1:0]     sursp_data,
  input  logic                                cursp_ready,
  output logic                                slot_release,
  output logic                                st_we,
  output cache_pkg::blk_state_t               st_nxt,
  output logic                                tag_we,
  output logic                                dat_we,
  output logic [cache_pkg::blk_width-1:0]     dat_in,
  output logic                                touch,
  output logic                                sdreq_valid,
  output cache_pkg::sdreq_op_t                sdreq_op,
  output logic [cache_pkg::saddr_width-1:0]   sdreq_addr,
  output logic                                sursp_ready,
  output logic                                cursp_valid,
  output logic [cache_pkg::blk_width-1:0]     cursp_data
);

  cache_pkg::req_state_t state, state_nxt;
  cache_pkg::sursp_rsp_t rsp_q;

  logic is_rd, is_wb, need_inv;
  logic sdreq_hs, sursp_hs, cursp_hs;

  assign is_rd    = (op_bf == cache_pkg::cdreq_rd);
  assign is_wb    = (op_bf == cache_pkg::cdreq_wb);
  // md or rfo on a shared line must invalidate other copies first
  assign need_inv = hit && (sel_state == cache_pkg::shared) &&
                    ((op_bf == cache_pkg::cdreq_md) || (op_bf == cache_pkg::cdreq_rfo));

  assign sdreq_hs = sdreq_valid && sdreq_ready;
  assign sursp_hs = sursp_valid && sursp_ready;
  assign cursp_hs = cursp_valid && cursp_ready;

  // ------------------------------------------------------------
  // request FSM
  // ------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      cache_pkg::st_idle:       if (full) state_nxt = cache_pkg::st_allocate;
      cache_pkg::st_allocate:   state_nxt = (hit && !need_inv) ? cache_pkg::st_send_rsp
                                                               : cache_pkg::st_init_sdreq;
      cache_pkg::st_init_sdreq: if (sdreq_hs) state_nxt = cache_pkg::st_wait_sursp;
      cache_pkg::st_wait_sursp: if (sursp_hs) state_nxt = cache_pkg::st_send_rsp;
      cache_pkg::st_send_rsp:   if (cursp_hs) state_nxt = cache_pkg::st_idle;
      default:                  state_nxt = cache_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cache_pkg::st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // fill kind decides shared vs exclusive later
  always_ff @(posedge clk) begin
    if (sursp_hs) begin
      rsp_q <= sursp_rsp;
    end
  end

  // ------------------------------------------------------------
  // channel outputs
  // ------------------------------------------------------------
  assign sdreq_valid = (state == cache_pkg::st_init_sdreq);
  assign sursp_ready = (state == cache_pkg::st_wait_sursp);
  assign cursp_valid = (state == cache_pkg::st_send_rsp);
  assign sdreq_addr  = addr_bf;

  always_comb begin
    if (need_inv) begin
      sdreq_op = cache_pkg::sdreq_inv;
    end else if (is_rd) begin
      sdreq_op = cache_pkg::sdreq_rd;
    end else begin
      sdreq_op = cache_pkg::sdreq_rfo;
    end
  end

  // only rd and rfo return the line
  assign cursp_data = (is_rd || op_bf == cache_pkg::cdreq_rfo) ? sel_data : '0;

  // ------------------------------------------------------------
  // line updates at the response handshake except fills
  // ------------------------------------------------------------
  assign slot_release = cursp_hs;
  assign touch        = cursp_hs;
  assign st_we        = cursp_hs;
  assign tag_we       = cursp_hs && !hit;

  always_comb begin
    if (hit && is_rd) begin
      st_nxt = sel_state;
    end else if (hit) begin
      st_nxt = is_wb ? cache_pkg::modified : cache_pkg::migrated;
    end else if (is_rd) begin
      st_nxt = (rsp_q == cache_pkg::sursp_snoop) ? cache_pkg::shared : cache_pkg::exclusive;
    end else begin
      st_nxt = cache_pkg::migrated;
    end
  end

  assign dat_we = (cursp_hs && is_wb) || (sursp_hs && !is_wb && !need_inv &&
                  (is_rd || op_bf == cache_pkg::cdreq_rfo));
  assign dat_in = is_wb ? data_bf : sursp_data;

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  a_cursp_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    cursp_valid && !cursp_ready |=> cursp_valid && $stable(cursp_data)
  );

  a_sdreq_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    sdreq_valid && !sdreq_ready |=> sdreq_valid && $stable(sdreq_op) && $stable(sdreq_addr)
  );

endmodule

/* design/cache_mem_top.sv */
`timescale 1ns/1ps

module cache_mem_top (
  input  logic                                clk,
  input  logic                                rst_n,
  // core request
  input  logic                                cdreq_valid,
  input  cache_pkg::cdreq_op_t                cdreq_op,
  input  logic [cache_pkg::saddr_width-1:0]   cdreq_addr,
  input  logic [cache_pkg::blk_width-1:0]     cdreq_data,
  output logic                                cdreq_ready,
  // core response
  output logic                                cursp_valid,
  output logic [cache_pkg::blk_width-1:0]     cursp_data,
  input  logic                                cursp_ready,
  // downstream request
  output logic                                sdreq_valid,
  output cache_pkg::sdreq_op_t                sdreq_op,
  output logic [cache_pkg::saddr_width-1:0]   sdreq_addr,
  input  logic                                sdreq_ready,
  // downstream response
  input  logic                                sursp_valid,
  input  cache_pkg::sursp_rsp_t               sursp_rsp,
  input  logic [cache_pkg::blk_width-1:0]     sursp_data,
  output logic                                sursp_ready
);

  logic                              full, slot_release;
  cache_pkg::cdreq_op_t              op_bf;
  logic [cache_pkg::saddr_width-1:0] addr_bf;
  logic [cache_pkg::blk_width-1:0]   data_bf;

  logic                              hit;
  logic [cache_pkg::way_width-1:0]   sel_way, victim_way;
  cache_pkg::blk_state_t             sel_state, st_nxt;
  logic [cache_pkg::blk_width-1:0]   sel_data, dat_in;
  logic                              st_we, tag_we, dat_we, touch;

  req_slot u_req_slot (
    .clk, .rst_n, .cdreq_valid, .cdreq_op, .cdreq_addr, .cdreq_data,
    .slot_release, .cdreq_ready, .full, .op_bf, .addr_bf, .data_bf
  );

  line_store u_line_store (
    .clk, .rst_n, .addr_bf, .victim_way, .st_we, .st_nxt, .tag_we, .dat_we, .dat_in,
    .hit, .sel_way, .sel_state, .sel_data
  );

  lru_tracker u_lru_tracker (
    .clk, .rst_n,
    .set_idx   (addr_bf[cache_pkg::idx_width-1:0]),
    .touch,
    .touch_way (sel_way),
    .victim_way
  );

  core_req_ctrl u_core_req_ctrl (
    .clk, .rst_n, .full, .op_bf, .addr_bf, .data_bf, .hit, .sel_state, .sel_data,
    .sdreq_ready, .sursp_valid, .sursp_rsp, .sursp_data, .cursp_ready,
    .slot_release, .st_we, .st_nxt, .tag_we, .dat_we, .dat_in, .touch,
    .sdreq_valid, .sdreq_op, .sdreq_addr, .sursp_ready, .cursp_valid, .cursp_data
  );

endmodule

/* dv/cache_mem_tb.sv */
`timescale 1ns/1ps

module cache_mem_tb;

  logic                                clk;
  logic                                rst_n;
  logic                                cdreq_valid;
  cache_pkg::cdreq_op_t                cdreq_op;
  logic [cache_pkg::saddr_width-1:0]   cdreq_addr;
  logic [cache_pkg::blk_width-1:0]     cdreq_data;
  logic                                cdreq_ready;
  logic                                cursp_valid;
  logic [cache_pkg::blk_width-1:0]     cursp_data;
  logic                                cursp_ready;
  logic                                sdreq_valid;
  cache_pkg::sdreq_op_t                sdreq_op;
  logic [cache_pkg::saddr_width-1:0]   sdreq_addr;
  logic                                sdreq_ready;
  logic                                sursp_valid;
  cache_pkg::sursp_rsp_t               sursp_rsp;
  logic [cache_pkg::blk_width-1:0]     sursp_data;
  logic                                sursp_ready;

  // one entry per case line
  string       names [$];
  logic [1:0]  ops [$];
  logic [15:0] addrs [$];
  logic [31:0] wdata [$];
  logic        rsps [$];
  logic [31:0] rdata [$];
  logic        sd_exp [$];
  logic [1:0]  sdop_exp [$];
  logic [31:0] cdata_exp [$];
  int          stalls [$];
  int          n_cases;
  integer      seed;

  cache_mem_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string tname, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      fail_run($sformatf("CHECK FAILED %s %s expected %h actual %h", tname, what, exp, act));
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          code;
    string       line;
    string       f_name;
    logic [1:0]  f_op;
    logic [15:0] f_addr;
    logic [31:0] f_data;
    logic        f_rsp;
    logic [31:0] f_rdata;
    logic        f_sd;
    logic [1:0]  f_sdop;
    logic [31:0] f_cdata;
    int          f_stall;
    fd = $fopen("dv/cache_cases.txt", "r");
    if (fd == 0) begin
      fail_run("could not open the case file dv/cache_cases.txt");
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code == 0) break;
      // comments and blank lines
      if (line.len() < 2 || line[0] == "#") continue;
      code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %d", f_name, f_op, f_addr, f_data,
                     f_rsp, f_rdata, f_sd, f_sdop, f_cdata, f_stall);
      if (code != 10) begin
        fail_run($sformatf("case file line could not be parsed: %s", line));
      end
      names.push_back(f_name);
      ops.push_back(f_op);
      addrs.push_back(f_addr);
      wdata.push_back(f_data);
      rsps.push_back(f_rsp);
      rdata.push_back(f_rdata);
      sd_exp.push_back(f_sd);
      sdop_exp.push_back(f_sdop);
      cdata_exp.push_back(f_cdata);
      stalls.push_back(f_stall);
    end
    $fclose(fd);
    n_cases = names.size();
  endtask

  // ------------------------------------------------------------
  // one request from start to core response handshake
  // ------------------------------------------------------------
  task automatic run_case(input int i);
    int          cyc;
    int          delay;
    int          sd_cyc;
    logic        saw_sd;
    logic        go_reply;
    logic        hs_sursp;
    logic [1:0]  sd_op;
    logic [15:0] sd_addr;
    cyc      = 0;
    sd_cyc   = 0;
    saw_sd   = 1'b0;
    go_reply = 1'b0;
    sd_op    = '0;
    sd_addr  = '0;
    cdreq_valid = 1'b1;
    cdreq_op    = cache_pkg::cdreq_op_t'(ops[i]);
    cdreq_addr  = addrs[i];
    cdreq_data  = wdata[i];
    while (!cdreq_ready) begin
      @(posedge clk);
      #1;
    end
    // acceptance edge
    @(posedge clk);
    #1;
    cdreq_valid = 1'b0;
    while (!cursp_valid) begin
      hs_sursp = sursp_valid && sursp_ready;
      if (sdreq_valid) begin
        sd_cyc++;
        if (sd_cyc == 1) begin
          saw_sd  = 1'b1;
          sd_op   = sdreq_op;
          sd_addr = sdreq_addr;
        end else if (sd_cyc == 2) begin
          // downstream request stalled for one cycle
          check_value(names[i], "sdreq_op held", sdop_exp[i], sdreq_op);
          check_value(names[i], "sdreq_addr held", addrs[i], sdreq_addr);
          sdreq_ready = 1'b1;
          go_reply    = 1'b1;
        end else begin
          fail_run($sformatf("%s: a second downstream request was sent", names[i]));
        end
      end
      @(posedge clk);
      #1;
      cyc++;
      sdreq_ready = 1'b0;
      if (hs_sursp) sursp_valid = 1'b0;
      // downstream responder
      if (go_reply) begin
        sursp_valid = 1'b1;
        sursp_rsp   = cache_pkg::sursp_rsp_t'(rsps[i]);
        sursp_data  = rdata[i];
        go_reply    = 1'b0;
      end
    end
    if (saw_sd !== sd_exp[i]) begin
      if (sd_exp[i]) begin
        fail_run($sformatf("%s: expected a downstream request but none was sent", names[i]));
      end else begin
        fail_run($sformatf("%s: a downstream request was sent on a plain hit", names[i]));
      end
    end
    if (saw_sd) begin
      check_value(names[i], "sdreq_op", sdop_exp[i], sd_op);
      check_value(names[i], "sdreq_addr", addrs[i], sd_addr);
    end else begin
      check_value(names[i], "hit latency", 2, cyc);
    end
    check_value(names[i], "cursp_data", cdata_exp[i], cursp_data);
    // core back-pressure with at least one stalled cycle when allowed
    delay = (stalls[i] == 0) ? 0 : 1 + int'($unsigned($random(seed)) % stalls[i]);
    repeat (delay) begin
      @(posedge clk);
      #1;
      check_value(names[i], "cursp_valid held", 1, cursp_valid);
      check_value(names[i], "cursp_data held", cdata_exp[i], cursp_data);
    end
    cursp_ready = 1'b1;
    @(posedge clk);
    #1;
    cursp_ready = 1'b0;
    check_value(names[i], "cursp_valid after handshake", 0, cursp_valid);
    check_value(names[i], "cdreq_ready after handshake", 1, cdreq_ready);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    rst_n       = 1'b0;
    cdreq_valid = 1'b0;
    cdreq_op    = cache_pkg::cdreq_rd;
    cdreq_addr  = '0;
    cdreq_data  = '0;
    cursp_ready = 1'b0;
    sdreq_ready = 1'b0;
    sursp_valid = 1'b0;
    sursp_rsp   = cache_pkg::sursp_snoop;
    sursp_data  = '0;
    seed        = 32'h44bd;
    n_cases     = 0;
    load_cases();
    if (n_cases == 0) begin
      fail_run("the case file holds no cases");
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n       = 1'b1;
    check_value("reset", "cdreq_ready", 1, cdreq_ready);
    check_value("reset", "cursp_valid", 0, cursp_valid);
    check_value("reset", "sdreq_valid", 0, sdreq_valid);
    check_value("reset", "sursp_ready", 0, sursp_ready);
    for (int i = 0; i < n_cases; i++) begin
      run_case(i);
    end
    $display("STATUS: PASS");
    $finish;
  end

  // watchdog sized from the case count
  initial begin
    wait (n_cases > 0);
    repeat (n_cases * 200 + 20) @(posedge clk);
    fail_run($sformatf("watchdog expired, %0d cases did not finish in %0d cycles",
                       n_cases, n_cases * 200 + 20));
  end

endmodule

/* dv/cache_cases.txt */
# name op addr data sursp_rsp sursp_data exp_sdreq exp_sdreq_op exp_cursp_data stall
# op 0 rd 1 md 2 wb 3 rfo, sursp_rsp 0 snoop 1 fetch, sdreq_op 0 rd 1 rfo 2 inv
rd_miss_a   0 0121 00000000 1 a5a50121 1 0 a5a50121 0
rd_hit_a    0 0121 00000000 1 00000000 0 0 a5a50121 2
rd_miss_b   0 0342 00000000 1 11110342 1 0 11110342 0
wb_hit_b    2 0342 deadbeef 1 00000000 0 0 00000000 1
rd_after_wb 0 0342 00000000 1 00000000 0 0 deadbeef 0
rd_snoop_c  0 0564 00000000 0 22220564 1 0 22220564 0
rfo_inv_c   3 0564 00000000 1 99999999 1 2 22220564 0
rfo_hit_c   3 0564 00000000 1 00000000 0 0 22220564 3
md_miss_d   1 0786 12345678 1 77770786 1 1 00000000 0
md_hit_d    1 0786 12345678 1 00000000 0 0 00000000 0
wb_miss_e   2 0987 cafef00d 1 88880987 1 1 00000000 0
rd_hit_e    0 0987 00000000 1 00000000 0 0 cafef00d 0
rfo_miss_f  3 0ab8 00000000 1 0ab80ab8 1 1 0ab80ab8 0
lru_fill_0  0 0015 00000000 1 50000015 1 0 50000015 0
lru_fill_1  0 0025 00000000 1 50000025 1 0 50000025 0
lru_fill_2  0 0035 00000000 1 50000035 1 0 50000035 0
lru_fill_3  0 0045 00000000 1 50000045 1 0 50000045 0
lru_fill_4  0 0055 00000000 1 50000055 1 0 50000055 0
lru_reread  0 0015 00000000 1 5a5a0015 1 0 5a5a0015 0
stall_rd_a  0 0121 00000000 1 00000000 0 0 a5a50121 8

/* sources.f */
design/cache_pkg.sv
design/req_slot.sv
design/line_store.sv
design/lru_tracker.sv
design/core_req_ctrl.sv
design/cache_mem_top.sv
dv/cache_mem_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module cache_mem_tb -Mdir obj_dir
	./obj_dir/Vcache_mem_tb

clean:
	rm -rf obj_dir
